// File: Bender.yml
package:
  name: muldiv

sources:
  - include_dirs:
      - .
    files:
      - muldiv_op_pkg.sv
      - muldiv_result_pkg.sv
      - leading_one_detect.sv
      - seq_multiplier.sv
      - iter_divider.sv
      - hilo_unit.sv
      - muldiv_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - muldiv_assertions.sv
      - tb_muldiv.sv

// File: all.f
+incdir+.
muldiv_op_pkg.sv
muldiv_result_pkg.sv
leading_one_detect.sv
seq_multiplier.sv
iter_divider.sv
hilo_unit.sv
muldiv_top.sv
muldiv_assertions.sv
tb_muldiv.sv

// File: hilo_unit.sv
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module hilo_unit import muldiv_result_pkg::*; (
    input  logic                     clk,
    input  logic                     rstn,
    input  muldiv_word_t             mul_product,
    input  logic                     mul_done,
    input  logic                     mul_busy,
    input  logic [`MULDIV_WIDTH-1:0] quotient,
    input  logic [`MULDIV_WIDTH-1:0] remainder,
    input  logic                     div_done,
    input  logic                     div_busy,
    output logic [`MULDIV_WIDTH-1:0] hi,
    output logic [`MULDIV_WIDTH-1:0] lo,
    output logic                     busy,
    output logic                     done
);

    muldiv_word_t hilo_q;       // architectural HI/LO
    logic         done_q;
    logic         wr_pending;

    // an engine result is waiting for the write edge
    assign wr_pending = mul_done | div_done;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            hilo_q <= '0;
            done_q <= 1'b0;
        end
        else
        begin
            done_q <= wr_pending;
            if (mul_done)
                hilo_q.full <= mul_product.full;
            else if (div_done)
            begin
                hilo_q.half.hi <= remainder;
                hilo_q.half.lo <= quotient;
            end
        end
    end

    assign hi   = hilo_q.half.hi;
    assign lo   = hilo_q.half.lo;
    assign done = done_q;
    assign busy = mul_busy | div_busy | wr_pending;

endmodule

// File: iter_divider.sv
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module iter_divider import muldiv_op_pkg::*; (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  muldiv_op_t               op,
    input  logic [`MULDIV_WIDTH-1:0] dividend,
    input  logic [`MULDIV_WIDTH-1:0] divisor,
    input  logic                     flush,
    output logic [`MULDIV_WIDTH-1:0] quotient,
    output logic [`MULDIV_WIDTH-1:0] remainder,
    output logic                     div_busy,
    output logic                     div_done
);

    localparam int W  = `MULDIV_WIDTH;
    localparam int CW = $clog2(`MULDIV_WIDTH) + 1;

    localparam logic [2:0] DIV_IDLE = 3'd0;
    localparam logic [2:0] DIV_INIT = 3'd1;
    localparam logic [2:0] DIV_CALC = 3'd2;
    localparam logic [2:0] DIV_HOLD = 3'd3;
    localparam logic [2:0] DIV_DONE = 3'd4;

    logic [2:0]     state;
    logic [2:0]     state_nxt;

    logic           op_signed;
    logic [W-1:0]   dvd_abs;
    logic [W-1:0]   dvs_abs;
    logic [CW-1:0]  dvd_bits;
    logic [CW-1:0]  dvs_bits;

    logic [CW-1:0]  dvd_bits_q;
    logic [CW-1:0]  dvs_bits_q;
    logic [CW-1:0]  iter_cnt;
    logic [2*W-1:0] rem_q;          // running partial remainder
    logic [2*W-1:0] dvs_q;          // divisor, aligned then shifted right
    logic [2*W-1:0] diff;
    logic [W-1:0]   quo_q;
    logic [W-1:0]   quo_nxt;
    logic [W-1:0]   rem_mag;
    logic           sgn_q;
    logic           dvd_neg_q;
    logic           dvs_neg_q;
    logic           early_exit;
    logic           last_iter;

    assign op_signed = is_signed_op(op);
    assign dvd_abs   = (op_signed && dividend[W-1]) ? -dividend : dividend;
    assign dvs_abs   = (op_signed && divisor[W-1]) ? -divisor : divisor;

    leading_one_detect u_lod_dvd (
        .in    (dvd_abs),
        .count (dvd_bits)
    );

    leading_one_detect u_lod_dvs (
        .in    (dvs_abs),
        .count (dvs_bits)
    );

    // divide by zero, or divisor wider than dividend
    assign early_exit = (dvs_bits_q == '0) || (dvs_bits_q > dvd_bits_q);
    assign last_iter  = (iter_cnt == dvd_bits_q - dvs_bits_q);

    assign diff    = rem_q - dvs_q;
    assign quo_nxt = {quo_q[W-2:0], ~diff[2*W-1]};
    assign rem_mag = diff[2*W-1] ? rem_q[W-1:0] : diff[W-1:0];

    assign div_busy = (state != DIV_IDLE);
    assign div_done = (state == DIV_DONE);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            state <= DIV_IDLE;
        else if (flush)
            state <= DIV_IDLE;      // abandon, no done
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            DIV_IDLE:
            begin
                if (start && is_div_op(op))
                    state_nxt = DIV_INIT;
            end
            DIV_INIT: state_nxt = early_exit ? DIV_HOLD : DIV_CALC;
            DIV_CALC:
            begin
                if (last_iter)
                    state_nxt = DIV_DONE;
            end
            DIV_HOLD: state_nxt = DIV_DONE;
            DIV_DONE: state_nxt = DIV_IDLE;
            default:  state_nxt = DIV_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        case (state)
            DIV_IDLE:
            begin
                if (start && is_div_op(op))
                begin
                    rem_q      <= {{W{1'b0}}, dvd_abs};
                    dvs_q      <= {{W{1'b0}}, dvs_abs};
                    dvd_bits_q <= dvd_bits;
                    dvs_bits_q <= dvs_bits;
                    sgn_q      <= op_signed;
                    dvd_neg_q  <= dividend[W-1];
                    dvs_neg_q  <= divisor[W-1];
                end
            end
            DIV_INIT:
            begin
                // put the divisor's leading one under the dividend's
                dvs_q    <= dvs_q << (dvd_bits_q - dvs_bits_q);
                iter_cnt <= '0;
                quo_q    <= '0;
            end
            DIV_CALC:
            begin
                if (!diff[2*W-1])
                    rem_q <= diff;
                quo_q    <= quo_nxt;
                dvs_q    <= dvs_q >> 1;
                iter_cnt <= iter_cnt + 1'b1;
                if (last_iter)
                begin
                    quotient  <= (sgn_q && (dvd_neg_q ^ dvs_neg_q)) ? -quo_nxt : quo_nxt;
                    remainder <= (sgn_q && dvd_neg_q) ? -rem_mag : rem_mag;
                end
            end
            DIV_HOLD:
            begin
                quotient  <= '0;
                remainder <= (sgn_q && dvd_neg_q) ? -rem_q[W-1:0] : rem_q[W-1:0];
            end
            default: ;
        endcase
    end

endmodule

// File: leading_one_detect.sv
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module leading_one_detect (
    input  logic [`MULDIV_WIDTH-1:0]       in,
    output logic [$clog2(`MULDIV_WIDTH):0] count
);

    localparam int CW = $clog2(`MULDIV_WIDTH) + 1;

    // scan upward so the highest set bit wins, zero input gives 0
    always_comb
    begin
        count = '0;
        for (int i = 0; i < `MULDIV_WIDTH; i++)
        begin
            if (in[i])
                count = CW'(i + 1);
        end
    end

endmodule

// File: muldiv_assertions.sv
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module muldiv_assertions import muldiv_op_pkg::*; (
    input logic       clk,
    input logic       rstn,
    input logic       start,
    input muldiv_op_t op,
    input logic       flush,
    input logic       busy,
    input logic       done
);

    int   sva_errors = 0;   // read by tb_muldiv
    logic flushed;          // flush seen since the last accepted start
    logic mul_start;

    assign mul_start = start && !busy && ((op == OP_MULT) || (op == OP_MULTU));

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            flushed <= 1'b0;
        else if (flush)
            flushed <= 1'b1;
        else if (start && !busy)
            flushed <= 1'b0;
    end

    a_done_single: assert property (@(posedge clk) disable iff (!rstn) done |=> !done)
    else
    begin
        sva_errors++;
        $error("done stayed high for two cycles");
    end

    // done lands MUL_LATENCY + 1 cycles after an accepted multiply start
    a_mul_latency: assert property (@(posedge clk) disable iff (!rstn || flush)
        mul_start |=> !done [*`MUL_LATENCY] ##1 done)
    else
    begin
        sva_errors++;
        $error("multiply done not exactly %0d cycles after start", `MUL_LATENCY + 1);
    end

    a_idle_after_done: assert property (@(posedge clk) disable iff (!rstn)
        (done && !start) |=> !busy)
    else
    begin
        sva_errors++;
        $error("busy high in the cycle after done");
    end

    a_no_done_after_flush: assert property (@(posedge clk) disable iff (!rstn) flushed |-> !done)
    else
    begin
        sva_errors++;
        $error("done pulsed after a flush without a new start");
    end

    a_reset_quiet: assert property (@(posedge clk) !rstn |-> (!busy && !done))
    else
    begin
        sva_errors++;
        $error("busy or done high during reset");
    end

endmodule

bind muldiv_top muldiv_assertions u_sva (
    .clk   (clk),
    .rstn  (rstn),
    .start (start),
    .op    (op),
    .flush (flush),
    .busy  (busy),
    .done  (done)
);

// File: muldiv_op_pkg.sv
package muldiv_op_pkg;

    // command from the execute stage
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_MULT  = 3'd1,
        OP_MULTU = 3'd2,
        OP_DIV   = 3'd3,
        OP_DIVU  = 3'd4
    } muldiv_op_t;

    function automatic logic is_mul_op(muldiv_op_t op);
        return (op == OP_MULT) || (op == OP_MULTU);
    endfunction

    function automatic logic is_div_op(muldiv_op_t op);
        return (op == OP_DIV) || (op == OP_DIVU);
    endfunction

    function automatic logic is_signed_op(muldiv_op_t op);
        return (op == OP_MULT) || (op == OP_DIV);
    endfunction

endpackage

// File: muldiv_result_pkg.sv
`include "muldiv_settings.svh"

package muldiv_result_pkg;

    // divider view, also the HI/LO read-out
    typedef struct packed {
        logic [`MULDIV_WIDTH-1:0] hi;   // remainder
        logic [`MULDIV_WIDTH-1:0] lo;   // quotient
    } hilo_pair_t;

    // one 64-bit word, either a full product or two halves
    typedef union packed {
        logic [2*`MULDIV_WIDTH-1:0] full;
        hilo_pair_t                 half;
    } muldiv_word_t;

endpackage

// File: muldiv_settings.svh
`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// operand width of both engines and of HI/LO
`define MULDIV_WIDTH 32

// cycles from the start pulse to mul_done
`define MUL_LATENCY 3

`endif

// File: muldiv_top.sv
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module muldiv_top import muldiv_op_pkg::*, muldiv_result_pkg::*; (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  muldiv_op_t               op,
    input  logic [`MULDIV_WIDTH-1:0] op_a,
    input  logic [`MULDIV_WIDTH-1:0] op_b,
    input  logic                     flush,
    output logic [`MULDIV_WIDTH-1:0] hi,
    output logic [`MULDIV_WIDTH-1:0] lo,
    output logic                     busy,
    output logic                     done
);

    muldiv_word_t             mul_product;
    logic                     mul_done;
    logic                     mul_busy;
    logic [`MULDIV_WIDTH-1:0] quotient;
    logic [`MULDIV_WIDTH-1:0] remainder;
    logic                     div_done;
    logic                     div_busy;

    seq_multiplier u_mul (
        .clk         (clk),
        .rstn        (rstn),
        .start       (start),
        .op          (op),
        .op_a        (op_a),
        .op_b        (op_b),
        .flush       (flush),
        .mul_product (mul_product),
        .mul_busy    (mul_busy),
        .mul_done    (mul_done)
    );

    // op_a is the dividend, op_b the divisor
    iter_divider u_div (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .op        (op),
        .dividend  (op_a),
        .divisor   (op_b),
        .flush     (flush),
        .quotient  (quotient),
        .remainder (remainder),
        .div_busy  (div_busy),
        .div_done  (div_done)
    );

    hilo_unit u_hilo (
        .clk         (clk),
        .rstn        (rstn),
        .mul_product (mul_product),
        .mul_done    (mul_done),
        .mul_busy    (mul_busy),
        .quotient    (quotient),
        .remainder   (remainder),
        .div_done    (div_done),
        .div_busy    (div_busy),
        .hi          (hi),
        .lo          (lo),
        .busy        (busy),
        .done        (done)
    );

endmodule

// File: seq_multiplier.sv
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module seq_multiplier import muldiv_op_pkg::*, muldiv_result_pkg::*; (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  muldiv_op_t               op,
    input  logic [`MULDIV_WIDTH-1:0] op_a,
    input  logic [`MULDIV_WIDTH-1:0] op_b,
    input  logic                     flush,
    output muldiv_word_t             mul_product,
    output logic                     mul_busy,
    output logic                     mul_done
);

    localparam int W = `MULDIV_WIDTH;

    logic [`MUL_LATENCY-1:0] stage_vld;   // one bit per pipeline stage
    logic                    accept;
    logic                    op_signed;
    logic [W-1:0]            mag_a;
    logic [W-1:0]            mag_b;
    logic                    neg_s1;
    logic                    neg_s2;
    logic [2*W-1:0]          prod_s2;

    assign op_signed = is_signed_op(op);
    assign accept    = start && is_mul_op(op) && (stage_vld == '0);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            stage_vld <= '0;
        else if (flush)
            stage_vld <= '0;
        else
            stage_vld <= {stage_vld[`MUL_LATENCY-2:0], accept};
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            mag_a  <= (op_signed && op_a[W-1]) ? -op_a : op_a;
            mag_b  <= (op_signed && op_b[W-1]) ? -op_b : op_b;
            neg_s1 <= op_signed && (op_a[W-1] ^ op_b[W-1]);
        end
        if (stage_vld[0])
        begin
            prod_s2 <= mag_a * mag_b;      // unsigned 64-bit
            neg_s2  <= neg_s1;
        end
        if (stage_vld[1])
            mul_product.full <= neg_s2 ? -prod_s2 : prod_s2;
    end

    assign mul_done = stage_vld[`MUL_LATENCY-1];
    assign mul_busy = |stage_vld[`MUL_LATENCY-2:0];

endmodule

// File: tb_muldiv.sv
`timescale 1ns/100ps
`include "muldiv_settings.svh"

module tb_muldiv import muldiv_op_pkg::*; ();

    localparam int W       = `MULDIV_WIDTH;
    localparam int TIMEOUT = 200;   // cycles

    logic         clk;
    logic         rstn;
    logic         start;
    muldiv_op_t   op;
    logic [W-1:0] op_a;
    logic [W-1:0] op_b;
    logic         flush;
    logic [W-1:0] hi;
    logic [W-1:0] lo;
    logic         busy;
    logic         done;

    integer       seed = 59342;
    int           errors = 0;
    int           timeouts = 0;

    logic [2*W-1:0] hilo_exp = '0;  // {hi, lo} of the last completed op

    muldiv_top UUT (
        .clk   (clk),
        .rstn  (rstn),
        .start (start),
        .op    (op),
        .op_a  (op_a),
        .op_b  (op_b),
        .flush (flush),
        .hi    (hi),
        .lo    (lo),
        .busy  (busy),
        .done  (done)
    );

    always #5 clk = ~clk;

    // {hi, lo} the way the CPU expects them
    function automatic logic [2*W-1:0] model_result(muldiv_op_t o, logic [W-1:0] x,
                                                    logic [W-1:0] y);
        longint       sx;
        longint       sy;
        logic [W-1:0] q;
        logic [W-1:0] r;
        sx = $signed(x);
        sy = $signed(y);
        if (o == OP_MULT)
            return sx * sy;
        if (o == OP_MULTU)
            return {{W{1'b0}}, x} * {{W{1'b0}}, y};
        if (y == '0)
        begin
            q = '0;     // divide by zero
            r = x;
        end
        else if (o == OP_DIV)
        begin
            q = W'(sx / sy);    // 64-bit math keeps min / -1 sane
            r = W'(sx % sy);
        end
        else
        begin
            q = x / y;
            r = x % y;
        end
        return {r, q};
    endfunction

    task automatic pulse_start(muldiv_op_t o, logic [W-1:0] x, logic [W-1:0] y);
        start = 1'b1;
        op    = o;
        op_a  = x;
        op_b  = y;
        @(posedge clk);
        #1;
        start = 1'b0;
        op    = OP_NONE;
    endtask

    task automatic wait_done(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            cycles++;
            seen = done;
        end
        if (!seen)
        begin
            timeouts++;
            $display("ERROR at %0t: done never arrived within %0d cycles", $time, TIMEOUT);
        end
    endtask

    task automatic check_result(muldiv_op_t o, logic [W-1:0] x, logic [W-1:0] y);
        logic [2*W-1:0] exp;
        exp      = model_result(o, x, y);
        hilo_exp = exp;
        assert ({hi, lo} == exp)
        else
        begin
            errors++;
            $display("MISMATCH at %0t: %s %h, %h gave hi=%h lo=%h, expected hi=%h lo=%h",
                     $time, o.name(), x, y, hi, lo, exp[2*W-1:W], exp[W-1:0]);
        end
    endtask

    task automatic run_op(muldiv_op_t o, logic [W-1:0] x, logic [W-1:0] y);
        logic seen;
        pulse_start(o, x, y);
        wait_done(seen);
        if (seen)
            check_result(o, x, y);
    endtask

    task automatic expect_no_done(int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            #1;
            assert (!done)
            else
            begin
                errors++;
                $display("MISMATCH at %0t: unexpected done pulse", $time);
            end
        end
    endtask

    task automatic flush_mid_op(muldiv_op_t o, logic [W-1:0] x, logic [W-1:0] y, int delay);
        pulse_start(o, x, y);
        repeat (delay)
        begin
            @(posedge clk);
            #1;
        end
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        assert (!busy)
        else
        begin
            errors++;
            $display("MISMATCH at %0t: busy still high after flush of %s", $time, o.name());
        end
        expect_no_done(40);
        assert ({hi, lo} == hilo_exp)
        else
        begin
            errors++;
            $display("MISMATCH at %0t: HI/LO changed by flushed %s, hi=%h lo=%h",
                     $time, o.name(), hi, lo);
        end
    endtask

    task automatic start_while_busy(muldiv_op_t o, logic [W-1:0] x1, logic [W-1:0] y1,
                                    logic [W-1:0] x2, logic [W-1:0] y2);
        logic seen;
        pulse_start(o, x1, y1);
        pulse_start(o, x2, y2);     // engine already running
        wait_done(seen);
        if (seen)
            check_result(o, x1, y1);
        expect_no_done(40);
    endtask

    initial
    begin
        logic [W-1:0] x;
        logic [W-1:0] y;
        clk   = 1'b0;
        rstn  = 1'b1;
        start = 1'b0;
        op    = OP_NONE;
        op_a  = '0;
        op_b  = '0;
        flush = 1'b0;
        #1 rstn = 1'b0;     // falling edge the async reset can see
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        assert (hi == '0 && lo == '0 && !busy && !done)
        else
        begin
            errors++;
            $display("MISMATCH at %0t: reset state hi=%h lo=%h busy=%b done=%b",
                     $time, hi, lo, busy, done);
        end

        run_op(OP_MULT, -3, -7);
        run_op(OP_MULT, 32'h8000_0000, 32'h8000_0000);
        run_op(OP_MULT, 32'h8000_0000, -1);
        run_op(OP_MULT, 12345, -678);
        run_op(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff);
        run_op(OP_MULTU, 32'h8000_0000, 2);

        run_op(OP_DIV, 100, 7);
        run_op(OP_DIV, -100, 7);
        run_op(OP_DIV, 100, -7);
        run_op(OP_DIV, -100, -7);
        run_op(OP_DIV, 32'h8000_0000, -1);
        run_op(OP_DIVU, 32'hffff_ffff, 1);
        run_op(OP_DIVU, 32'hffff_ffff, 32'h8000_0000);

        // early exits
        run_op(OP_DIVU, 5, 100);
        run_op(OP_DIV, -5, 100);
        run_op(OP_DIVU, 7, 0);
        run_op(OP_DIV, -7, 0);

        for (int i = 0; i < 20; i++)
        begin
            x = $random(seed);
            y = $random(seed);
            run_op(OP_MULT, x, y);
            run_op(OP_MULTU, y, x);
            y = y >> ($unsigned($random(seed)) % W);  // vary the divisor width
            run_op(OP_DIV, x, y);
            run_op(OP_DIVU, x, y);
        end

        flush_mid_op(OP_DIVU, 32'h7fff_ffff, 3, 5);
        flush_mid_op(OP_MULT, -9, 11, 1);
        start_while_busy(OP_MULTU, 32'hdead_beef, 17, 3, 5);
        start_while_busy(OP_DIV, -1000, 9, 77, 2);

        $display("checks failed: %0d, timeouts: %0d, assertion failures: %0d",
                 errors, timeouts, UUT.u_sva.sva_errors);
        if (errors == 0 && timeouts == 0 && UUT.u_sva.sva_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
